//--- source/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // funct3 for alu operations
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branches and memory access
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;

    // one instruction word, viewed in each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

//--- source/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    // word address into each memory, 1024 words
    localparam int ADDR_WIDTH = 10;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // first alu operand
    typedef enum logic [1:0] {
        SRC_A_PC   = 2'd0,
        SRC_A_ZERO = 2'd1,
        SRC_A_RS1  = 2'd2
    } src_a_e;

    // register write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

//--- source/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // branch compare runs through sub, so zero means equal
    assign zero = (result == '0);

endmodule

//--- source/control_unit.sv
`timescale 1ns/1ps

module control_unit import riscv_isa_pkg::*, core_pkg::*; (
    input  instr_u  instr,
    output logic    branch,
    output logic    jump,
    output logic    mem_write,
    output logic    alu_src_imm,
    output logic    reg_write,
    output src_a_e  src_a_sel,
    output wb_sel_e wb_sel
);

    always_comb begin
        // unknown opcodes fall through as a no-op
        branch      = 1'b0;
        jump        = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        src_a_sel   = SRC_A_RS1;
        wb_sel      = WB_ALU;

        case (instr.r_fmt.opcode)
            OP_REG: begin
                reg_write = 1'b1;
            end
            OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_BRANCH: begin
                branch = 1'b1;
            end
            OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                src_a_sel   = SRC_A_ZERO;
            end
            OP_AUIPC: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                src_a_sel   = SRC_A_PC;
            end
            OP_JAL: begin
                // link value is pc+4, target comes from the pc adder
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = WB_PC4;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- source/alu_control.sv
`timescale 1ns/1ps

module alu_control import riscv_isa_pkg::*, core_pkg::*; (
    input  instr_u  instr,
    output alu_op_e alu_op
);

    logic bit30;
    logic is_reg;

    assign bit30  = instr.r_fmt.funct7[5];
    assign is_reg = (instr.r_fmt.opcode == OP_REG);

    always_comb begin
        case (instr.r_fmt.opcode)
            OP_REG, OP_IMM: begin
                case (instr.r_fmt.funct3)
                    // addi has no sub form, bit 30 is immediate there
                    F3_ADD_SUB: alu_op = (is_reg && bit30) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = bit30 ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_op = ALU_ADD;
                endcase
            end
            OP_BRANCH: begin
                alu_op = ALU_SUB;
            end
            // address and upper-immediate forms all add
            default: begin
                alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [XLEN-1:0] wdata,
    input  logic            write,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero whatever is stored
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- source/immediate_generator.sv
`timescale 1ns/1ps

module immediate_generator import riscv_isa_pkg::*, core_pkg::*; (
    input  instr_u          instr,
    output logic [XLEN-1:0] imm
);

    always_comb begin
        case (instr.r_fmt.opcode)
            OP_IMM, OP_LOAD: begin
                imm = {{(XLEN-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            end
            OP_STORE: begin
                imm = {{(XLEN-12){instr.s_fmt.imm_11_5[6]}},
                       instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
            end
            OP_BRANCH: begin
                // offset is in halfwords, bit 0 always zero
                imm = {{(XLEN-13){instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                       instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                       instr.b_fmt.imm_4_1, 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instr.u_fmt.imm_31_12, 12'b0};
            end
            OP_JAL: begin
                imm = {{(XLEN-21){instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                       instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                       instr.j_fmt.imm_10_1, 1'b0};
            end
            // r-type carries no immediate
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core import riscv_isa_pkg::*, core_pkg::*; (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic [XLEN-1:0]       rom_data,
    input  logic [XLEN-1:0]       ram_rdata,
    output logic [ADDR_WIDTH-1:0] rom_addr,
    output logic [ADDR_WIDTH-1:0] ram_addr,
    output logic [XLEN-1:0]       ram_wdata,
    output logic                  ram_write
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] pc_next;
    instr_u          instr;

    logic            branch;
    logic            jump;
    logic            alu_src_imm;
    logic            reg_write;
    src_a_e          src_a_sel;
    wb_sel_e         wb_sel;
    alu_op_e         alu_op;

    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic [XLEN-1:0] wb_data;
    logic            taken;

    assign instr = rom_data;

    control_unit u_control (
        .instr       (instr),
        .branch      (branch),
        .jump        (jump),
        .mem_write   (ram_write),
        .alu_src_imm (alu_src_imm),
        .reg_write   (reg_write),
        .src_a_sel   (src_a_sel),
        .wb_sel      (wb_sel)
    );

    alu_control u_alu_control (
        .instr  (instr),
        .alu_op (alu_op)
    );

    register_file u_regs (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (instr.r_fmt.rs1),
        .rs2     (instr.r_fmt.rs2),
        .rd      (instr.r_fmt.rd),
        .wdata   (wb_data),
        .write   (reg_write),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    immediate_generator u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    always_comb begin
        case (src_a_sel)
            SRC_A_PC:   operand_a = pc;
            SRC_A_ZERO: operand_a = '0;
            default:    operand_a = rdata1;
        endcase
    end

    assign operand_b = alu_src_imm ? imm : rdata2;

    alu u_alu (
        .a      (operand_a),
        .b      (operand_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = ram_rdata;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // beq and bne only, other conditions never take
    always_comb begin
        taken = 1'b0;
        if (branch) begin
            case (instr.b_fmt.funct3)
                F3_BEQ:  taken = alu_zero;
                F3_BNE:  taken = !alu_zero;
                default: taken = 1'b0;
            endcase
        end
    end

    assign pc_plus4  = pc + XLEN'(4);
    assign pc_target = pc + imm;
    assign pc_next   = (taken || jump) ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // both memories are word addressed
    assign rom_addr  = pc[ADDR_WIDTH+1:2];
    assign ram_addr  = alu_result[ADDR_WIDTH+1:2];
    assign ram_wdata = rdata2;

endmodule

//--- tb/rv32i_core_tb.sv
`timescale 1ns/1ps

module rv32i_core_tb import riscv_isa_pkg::*, core_pkg::*; ();

    logic                  CLK;
    logic                  RESET_N;
    logic [XLEN-1:0]       rom_data;
    logic [XLEN-1:0]       ram_rdata;
    logic [ADDR_WIDTH-1:0] rom_addr;
    logic [ADDR_WIDTH-1:0] ram_addr;
    logic [XLEN-1:0]       ram_wdata;
    logic                  ram_write;

    logic [XLEN-1:0]       imem [0:(1<<ADDR_WIDTH)-1];
    logic [XLEN-1:0]       dmem [0:(1<<ADDR_WIDTH)-1];

    // committed stores and the stores the test expects, in order
    logic [ADDR_WIDTH-1:0] store_addr_q [$];
    logic [XLEN-1:0]       store_data_q [$];
    logic [ADDR_WIDTH-1:0] exp_addr_q [$];
    logic [XLEN-1:0]       exp_data_q [$];

    int                    prog_len;
    int                    cycle_count;
    int                    cycle_budget;

    rv32i_core UUT (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .rom_data  (rom_data),
        .ram_rdata (ram_rdata),
        .rom_addr  (rom_addr),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_write (ram_write)
    );

    always #2 CLK = ~CLK;

    // both memories read combinationally
    assign rom_data  = imem[rom_addr];
    assign ram_rdata = dmem[ram_addr];

    always @(posedge CLK) begin
        if (RESET_N && ram_write) begin
            dmem[ram_addr] = ram_wdata;
            store_addr_q.push_back(ram_addr);
            store_data_q.push_back(ram_wdata);
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > cycle_budget) begin
            abort_run("global cycle limit exceeded, the core never settled");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        instr_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = OP_REG;
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        instr_u w;
        w.i_fmt.imm_11_0 = imm;
        w.i_fmt.rs1      = rs1;
        w.i_fmt.funct3   = f3;
        w.i_fmt.rd       = rd;
        w.i_fmt.opcode   = opcode;
        return w;
    endfunction

    function automatic logic [31:0] sw_word(input logic [11:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        instr_u w;
        w.s_fmt.imm_11_5 = off[11:5];
        w.s_fmt.rs2      = rs2;
        w.s_fmt.rs1      = rs1;
        w.s_fmt.funct3   = F3_WORD;
        w.s_fmt.imm_4_0  = off[4:0];
        w.s_fmt.opcode   = OP_STORE;
        return w;
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        instr_u w;
        w.b_fmt.imm_12   = off[12];
        w.b_fmt.imm_10_5 = off[10:5];
        w.b_fmt.rs2      = rs2;
        w.b_fmt.rs1      = rs1;
        w.b_fmt.funct3   = f3;
        w.b_fmt.imm_4_1  = off[4:1];
        w.b_fmt.imm_11   = off[11];
        w.b_fmt.opcode   = OP_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] upper, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        instr_u w;
        w.u_fmt.imm_31_12 = upper;
        w.u_fmt.rd        = rd;
        w.u_fmt.opcode    = opcode;
        return w;
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        instr_u w;
        w.j_fmt.imm_20    = off[20];
        w.j_fmt.imm_10_1  = off[10:1];
        w.j_fmt.imm_11    = off[11];
        w.j_fmt.imm_19_12 = off[19:12];
        w.j_fmt.rd        = rd;
        w.j_fmt.opcode    = OP_JAL;
        return w;
    endfunction

    // reference results straight from the instruction set rules
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            F3_ADD_SUB: begin
                if (alt) return a - b;
                return a + b;
            end
            F3_SLL:  return a << sh;
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SRL_SRA: begin
                if (alt) return $signed(a) >>> sh;
                return a >> sh;
            end
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // lui+addi, upper part rounded so the signed low part lands exactly
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(u_word(upper[31:12], rd, OP_LUI));
        emit(i_word(value[11:0], rd, F3_ADD_SUB, rd, OP_IMM));
    endtask

    task automatic store_checked(input logic [4:0] rs2, input logic [4:0] rs1,
                                 input logic [31:0] base, input logic [11:0] off,
                                 input logic [31:0] value);
        logic [31:0] ea;
        ea = base + {{20{off[11]}}, off};
        emit(sw_word(off, rs2, rs1));
        exp_addr_q.push_back(ea[11:2]);
        exp_data_q.push_back(value);
    endtask

    // core held in reset while the next program is written
    task automatic start_test();
        int i;
        @(negedge CLK);
        RESET_N = 1'b0;
        prog_len = 0;
        for (i = 0; i < (1 << ADDR_WIDTH); i++) begin
            imem[i] = '0;
        end
        store_addr_q.delete();
        store_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic check_stores();
        int i;
        assert (store_addr_q.size() == exp_addr_q.size()) else
            abort_run($sformatf("mismatch at %0t: ram_write count expected %0d got %0d",
                                $time, exp_addr_q.size(), store_addr_q.size()));
        for (i = 0; i < exp_addr_q.size(); i++) begin
            assert (store_addr_q[i] == exp_addr_q[i]) else
                abort_run($sformatf("mismatch at %0t: ram_addr of store %0d expected %h got %h",
                                    $time, i, exp_addr_q[i], store_addr_q[i]));
            assert (store_data_q[i] == exp_data_q[i]) else
                abort_run($sformatf("mismatch at %0t: ram_wdata of store %0d expected %h got %h",
                                    $time, i, exp_data_q[i], store_data_q[i]));
        end
    endtask

    task automatic run_program();
        logic [ADDR_WIDTH-1:0] loop_addr;
        int limit;
        int waited;
        loop_addr = ADDR_WIDTH'(prog_len);
        // jal x0 to itself parks the core
        emit(jal_word(21'd0, 5'd0));
        limit = prog_len + 10;
        cycle_budget = cycle_budget + limit + 4;
        repeat (2) @(negedge CLK);
        RESET_N = 1'b1;
        waited = 0;
        while (rom_addr != loop_addr) begin
            @(negedge CLK);
            waited++;
            assert (waited <= limit) else
                abort_run($sformatf("program never reached its final loop within %0d cycles",
                                    limit));
        end
        check_stores();
    endtask

    task automatic r_type_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        alt;
        int          i;
        start_test();
        a = $urandom();
        b = $urandom();
        load_const(5'd1, a);
        load_const(5'd2, b);
        // eight funct3 values, then sub and sra
        for (i = 0; i < 10; i++) begin
            f3  = (i < 8) ? 3'(i) : ((i == 8) ? F3_ADD_SUB : F3_SRL_SRA);
            alt = (i >= 8);
            emit(r_word({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd3));
            store_checked(5'd3, 5'd0, 32'd0, 12'(64 + 4 * i), alu_model(f3, alt, a, b));
        end
        run_program();
    endtask

    task automatic i_type_and_upper();
        logic [31:0] a;
        logic [31:0] pc;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [2:0]  f3;
        int          i;
        start_test();
        a = $urandom();
        load_const(5'd1, a);
        for (i = 0; i < 9; i++) begin
            f3  = (i < 8) ? 3'(i) : F3_SRL_SRA;
            imm = 12'($urandom());
            if (i == 0) begin
                imm[11] = 1'b1;
            end
            // shifts carry shamt plus the sra bit
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                imm = {1'b0, i == 8, 5'b0, imm[4:0]};
            end
            emit(i_word(imm, 5'd1, f3, 5'd3, OP_IMM));
            store_checked(5'd3, 5'd0, 32'd0, 12'(128 + 4 * i),
                          alu_model(f3, i == 8, a, {{20{imm[11]}}, imm}));
        end
        upper = 20'($urandom());
        emit(u_word(upper, 5'd4, OP_LUI));
        store_checked(5'd4, 5'd0, 32'd0, 12'd200, {upper, 12'h000});
        upper = 20'($urandom());
        pc = 32'(prog_len * 4);
        emit(u_word(upper, 5'd5, OP_AUIPC));
        store_checked(5'd5, 5'd0, 32'd0, 12'd204, pc + {upper, 12'h000});
        run_program();
    endtask

    task automatic load_store_round_trip();
        logic [31:0] data;
        logic [11:0] delta;
        int          i;
        start_test();
        load_const(5'd7, 32'd400);
        for (i = 0; i < 4; i++) begin
            data = $urandom();
            delta = 12'($urandom());
            dmem[100 + i] = data;
            emit(i_word(12'(4 * i), 5'd7, F3_WORD, 5'd6, OP_LOAD));
            emit(i_word(delta, 5'd6, F3_ADD_SUB, 5'd6, OP_IMM));
            store_checked(5'd6, 5'd7, 32'd400, 12'(200 + 4 * i),
                          data + {{20{delta[11]}}, delta});
        end
        run_program();
    endtask

    task automatic branch_paths();
        logic [31:0] v;
        logic [31:0] fall_val;
        logic [31:0] mark;
        logic        equal_ops;
        logic        is_bne;
        int          i;
        start_test();
        v = $urandom();
        fall_val = $urandom();
        mark = $urandom();
        load_const(5'd1, v);
        load_const(5'd2, v);
        load_const(5'd3, v ^ 32'h0000_0100);
        load_const(5'd9, fall_val);
        load_const(5'd10, mark);
        // beq/bne against equal and unequal operands, each skipping one store
        for (i = 0; i < 4; i++) begin
            is_bne    = (i >= 2);
            equal_ops = (i % 2 == 1);
            emit(b_word(13'd8, equal_ops ? 5'd2 : 5'd3, 5'd1, is_bne ? F3_BNE : F3_BEQ));
            if (is_bne != equal_ops) begin
                emit(sw_word(12'(256 + 8 * i), 5'd9, 5'd0));
            end else begin
                store_checked(5'd9, 5'd0, 32'd0, 12'(256 + 8 * i), fall_val);
            end
            store_checked(5'd10, 5'd0, 32'd0, 12'(260 + 8 * i), mark);
        end
        run_program();
    endtask

    task automatic jal_and_x0();
        logic [31:0] link;
        start_test();
        load_const(5'd1, $urandom());
        link = 32'(prog_len * 4 + 4);
        emit(jal_word(21'd8, 5'd1));
        emit(sw_word(12'd512, 5'd0, 5'd0));
        store_checked(5'd1, 5'd0, 32'd0, 12'd516, link);
        // none of these may change x0
        load_const(5'd0, $urandom());
        emit(r_word(7'd0, 5'd1, 5'd1, F3_ADD_SUB, 5'd0));
        store_checked(5'd0, 5'd0, 32'd0, 12'd520, 32'd0);
        run_program();
    endtask

    initial begin
        int i;
        void'($urandom(32'hfebf));
        CLK = 1'b0;
        RESET_N = 1'b0;
        cycle_count = 0;
        cycle_budget = 4;
        prog_len = 0;
        for (i = 0; i < (1 << ADDR_WIDTH); i++) begin
            imem[i] = '0;
            dmem[i] = 32'h5a5a_0000 ^ 32'(i);
        end
        r_type_alu();
        i_type_and_upper();
        load_store_round_trip();
        branch_paths();
        jal_and_x0();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- sources.f
source/riscv_isa_pkg.sv
source/core_pkg.sv
source/alu.sv
source/control_unit.sv
source/alu_control.sv
source/register_file.sv
source/immediate_generator.sv
source/rv32i_core.sv
tb/rv32i_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv32i_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module rv32i_core_tb \
    -o rv32i_core_sim

./obj_dir/rv32i_core_sim
